/* verilog/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data path and address width
`define RV_XLEN 32

// Register file geometry
`define RV_REG_NUM    32
`define RV_REG_ADDR_W 5

// PC after reset and sequential increment
`define RV_RESET_PC  32'h0000_0000
`define RV_INST_STEP 32'd4

// ADDI x0, x0, 0
`define RV_NOP_INST 32'h0000_0013

`endif

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Major opcodes kept by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ = 3'b000,
    BR_BNE = 3'b001
  } br_funct3_e;

  // funct3 of OP / OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // Word size for LW/SW
  localparam logic [2:0] F3_WORD    = 3'b010;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* verilog/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_WB
  } core_state_e;

  // Writeback value source
  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_LINK
  } wb_src_e;

endpackage

/* verilog/rv_fetch.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_start_i,
  input  logic                wb_en_i,
  input  logic [`RV_XLEN-1:0] next_pc_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  output logic                imem_read_o,
  input  logic [`RV_XLEN-1:0] imem_read_data_i,
  input  logic                imem_ready_i,
  output logic [`RV_XLEN-1:0] pc_o,
  output logic [`RV_XLEN-1:0] inst_o,
  output logic                fetch_done_o
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] inst_q;
  logic                req_q;
  logic                accept;

  // Handshake completes on the edge where ready is seen
  assign accept = req_q && imem_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q   <= `RV_RESET_PC;
      req_q  <= 1'b0;
      inst_q <= `RV_NOP_INST;
    end else begin
      if (wb_en_i) begin
        pc_q <= next_pc_i;
      end
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (accept) begin
        req_q <= 1'b0;
      end
      if (accept) begin
        inst_q <= imem_read_data_i;
      end
    end
  end

  assign imem_addr_o  = pc_q;
  assign imem_read_o  = req_q;
  assign pc_o         = pc_q;
  assign inst_o       = inst_q;
  assign fetch_done_o = accept;

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_decode import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic [`RV_XLEN-1:0]       inst_i,
  output logic [`RV_REG_ADDR_W-1:0] rs1_o,
  output logic [`RV_REG_ADDR_W-1:0] rs2_o,
  output logic [`RV_REG_ADDR_W-1:0] rd_o,
  output logic [`RV_XLEN-1:0]       imm_o,
  output alu_op_e                   alu_op_o,
  output logic                      alu_src_imm_o,
  output logic                      reg_write_o,
  output logic                      is_load_o,
  output logic                      is_store_o,
  output logic                      is_branch_o,
  output logic                      is_jal_o,
  output br_funct3_e                br_funct3_o,
  output wb_src_e                   wb_src_o
);

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                f7_base;
  logic                f7_alt;
  logic [`RV_XLEN-1:0] imm_i_fmt;
  logic [`RV_XLEN-1:0] imm_s_fmt;
  logic [`RV_XLEN-1:0] imm_b_fmt;
  logic [`RV_XLEN-1:0] imm_u_fmt;
  logic [`RV_XLEN-1:0] imm_j_fmt;

  // Map funct3 to an ALU op with alt selecting SUB or SRA
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_sel = ALU_SLL;
      F3_SLT:     alu_sel = ALU_SLT;
      F3_SLTU:    alu_sel = ALU_SLTU;
      F3_XOR:     alu_sel = ALU_XOR;
      F3_SR:      alu_sel = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_sel = ALU_OR;
      default:    alu_sel = ALU_AND;
    endcase
  endfunction

  assign funct3  = inst_i[14:12];
  assign funct7  = inst_i[31:25];
  assign f7_base = (funct7 == F7_BASE);
  assign f7_alt  = (funct7 == F7_ALT);

  assign rs1_o = inst_i[19:15];
  assign rs2_o = inst_i[24:20];
  assign rd_o  = inst_i[11:7];

  // Immediate formats
  assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_fmt = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
  assign imm_u_fmt = {inst_i[31:12], 12'b0};
  assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};

  assign br_funct3_o = br_funct3_e'(funct3);

  always_comb begin
    imm_o         = imm_i_fmt;
    alu_op_o      = ALU_ADD;
    alu_src_imm_o = 1'b1;
    reg_write_o   = 1'b0;
    is_load_o     = 1'b0;
    is_store_o    = 1'b0;
    is_branch_o   = 1'b0;
    is_jal_o      = 1'b0;
    wb_src_o      = WB_ALU;
    case (opcode_e'(inst_i[6:0]))
      OPC_OP: begin
        alu_src_imm_o = 1'b0;
        alu_op_o      = alu_sel(funct3, funct7[5]);
        // Only SUB and SRA accept the alternate funct7
        reg_write_o   = f7_base || (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
      end
      OPC_OP_IMM: begin
        alu_op_o = alu_sel(funct3, (funct3 == F3_SR) && funct7[5]);
        case (funct3)
          F3_SLL:  reg_write_o = f7_base;
          F3_SR:   reg_write_o = f7_base || f7_alt;
          default: reg_write_o = 1'b1;
        endcase
      end
      OPC_LUI: begin
        imm_o       = imm_u_fmt;
        alu_op_o    = ALU_PASS_B;
        reg_write_o = 1'b1;
      end
      OPC_LOAD: begin
        is_load_o   = (funct3 == F3_WORD);
        reg_write_o = (funct3 == F3_WORD);
        wb_src_o    = WB_LOAD;
      end
      OPC_STORE: begin
        imm_o      = imm_s_fmt;
        is_store_o = (funct3 == F3_WORD);
      end
      OPC_BRANCH: begin
        imm_o         = imm_b_fmt;
        alu_src_imm_o = 1'b0;
        is_branch_o   = (funct3 == BR_BEQ) || (funct3 == BR_BNE);
      end
      OPC_JAL: begin
        imm_o       = imm_j_fmt;
        is_jal_o    = 1'b1;
        reg_write_o = 1'b1;
        wb_src_o    = WB_LINK;
      end
      // Anything else retires as a no-op
      default: ;
    endcase
  end

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
  output logic [`RV_XLEN-1:0]       rs1_data_o,
  output logic [`RV_XLEN-1:0]       rs2_data_o,
  input  logic                      we_i,
  input  logic [`RV_REG_ADDR_W-1:0] rd_addr_i,
  input  logic [`RV_XLEN-1:0]       rd_data_i
);

  logic [`RV_XLEN-1:0] regs_q [`RV_REG_NUM];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  // x0 reads zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_execute import rv_isa_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                exec_en_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  logic [`RV_XLEN-1:0] rs1_data_i,
  input  logic [`RV_XLEN-1:0] rs2_data_i,
  input  logic [`RV_XLEN-1:0] imm_i,
  input  alu_op_e             alu_op_i,
  input  logic                alu_src_imm_i,
  input  logic                is_branch_i,
  input  logic                is_jal_i,
  input  br_funct3_e          br_funct3_i,
  output logic [`RV_XLEN-1:0] alu_result_o,
  output logic [`RV_XLEN-1:0] store_data_o,
  output logic [`RV_XLEN-1:0] next_pc_o
);

  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic [`RV_XLEN-1:0] alu_d;
  logic                br_taken;
  logic [`RV_XLEN-1:0] next_pc_d;

  assign op_b  = alu_src_imm_i ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  // ==================================================
  // ALU
  // ==================================================
  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_d = rs1_data_i + op_b;
      ALU_SUB:    alu_d = rs1_data_i - op_b;
      ALU_SLL:    alu_d = rs1_data_i << shamt;
      ALU_SLT:    alu_d = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
      ALU_SLTU:   alu_d = {31'b0, rs1_data_i < op_b};
      ALU_XOR:    alu_d = rs1_data_i ^ op_b;
      ALU_SRL:    alu_d = rs1_data_i >> shamt;
      ALU_SRA:    alu_d = $signed(rs1_data_i) >>> shamt;
      ALU_OR:     alu_d = rs1_data_i | op_b;
      ALU_AND:    alu_d = rs1_data_i & op_b;
      ALU_PASS_B: alu_d = op_b;
      default:    alu_d = '0;
    endcase
  end

  // ==================================================
  // Branch and next PC
  // ==================================================
  always_comb begin
    case (br_funct3_i)
      BR_BEQ:  br_taken = is_branch_i && (rs1_data_i == rs2_data_i);
      BR_BNE:  br_taken = is_branch_i && (rs1_data_i != rs2_data_i);
      default: br_taken = 1'b0;
    endcase
  end

  assign next_pc_d = (is_jal_i || br_taken) ? pc_i + imm_i : pc_i + `RV_INST_STEP;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_result_o <= '0;
      store_data_o <= '0;
      next_pc_o    <= `RV_RESET_PC;
    end else if (exec_en_i) begin
      alu_result_o <= alu_d;
      store_data_o <= rs2_data_i;
      next_pc_o    <= next_pc_d;
    end
  end

endmodule

/* verilog/rv_mem_access.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_mem_access import rv_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                mem_start_i,
  input  logic                wb_en_i,
  input  logic                is_load_i,
  input  logic                is_store_i,
  input  logic [`RV_XLEN-1:0] addr_i,
  input  logic [`RV_XLEN-1:0] store_data_i,
  input  logic [`RV_XLEN-1:0] alu_result_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  wb_src_e             wb_src_i,
  input  logic                reg_write_i,
  output logic [`RV_XLEN-1:0] dmem_addr_o,
  output logic [`RV_XLEN-1:0] dmem_write_data_o,
  output logic                dmem_read_o,
  output logic                dmem_write_o,
  input  logic [`RV_XLEN-1:0] dmem_read_data_i,
  input  logic                dmem_ready_i,
  output logic                mem_done_o,
  output logic                rd_we_o,
  output logic [`RV_XLEN-1:0] rd_data_o
);

  logic                read_q;
  logic                write_q;
  logic                accept;
  logic [`RV_XLEN-1:0] load_data_q;

  assign accept = (read_q || write_q) && dmem_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else if (mem_start_i) begin
      // Decode never flags both for one instruction
      read_q  <= is_load_i;
      write_q <= is_store_i;
    end else if (accept) begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_data_q <= '0;
    end else if (accept && read_q) begin
      load_data_q <= dmem_read_data_i;
    end
  end

  assign dmem_addr_o       = addr_i;
  assign dmem_write_data_o = store_data_i;
  assign dmem_read_o       = read_q;
  assign dmem_write_o      = write_q;
  assign mem_done_o        = accept;

  // Writeback select
  always_comb begin
    case (wb_src_i)
      WB_LOAD: rd_data_o = load_data_q;
      WB_LINK: rd_data_o = pc_i + `RV_INST_STEP;
      default: rd_data_o = alu_result_i;
    endcase
  end

  assign rd_we_o = wb_en_i && reg_write_i;

endmodule

/* verilog/rv_core_fsm.sv */
`timescale 1ns/10ps

module rv_core_fsm import rv_ctrl_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic fetch_done_i,
  input  logic mem_done_i,
  input  logic is_load_i,
  input  logic is_store_i,
  output logic fetch_start_o,
  output logic decode_en_o,
  output logic exec_en_o,
  output logic mem_start_o,
  output logic wb_en_o
);

  core_state_e state_q;
  core_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   state_d = ST_FETCH;
      ST_FETCH:  if (fetch_done_i) state_d = ST_DECODE;
      ST_DECODE: state_d = ST_EXEC;
      // Only LW/SW go through the data port
      ST_EXEC:   state_d = (is_load_i || is_store_i) ? ST_MEM : ST_WB;
      ST_MEM:    if (mem_done_i) state_d = ST_WB;
      ST_WB:     state_d = ST_FETCH;
      default:   state_d = ST_IDLE;
    endcase
  end

  // Strobes are high in the first cycle of their state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= ST_IDLE;
      fetch_start_o <= 1'b0;
      decode_en_o   <= 1'b0;
      exec_en_o     <= 1'b0;
      mem_start_o   <= 1'b0;
      wb_en_o       <= 1'b0;
    end else begin
      state_q       <= state_d;
      fetch_start_o <= (state_d == ST_FETCH) && (state_q != ST_FETCH);
      decode_en_o   <= (state_d == ST_DECODE) && (state_q != ST_DECODE);
      exec_en_o     <= (state_d == ST_EXEC) && (state_q != ST_EXEC);
      mem_start_o   <= (state_d == ST_MEM) && (state_q != ST_MEM);
      wb_en_o       <= (state_d == ST_WB) && (state_q != ST_WB);
    end
  end

endmodule

/* verilog/rv_core_top.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_core_top import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  output logic                imem_read_o,
  input  logic [`RV_XLEN-1:0] imem_read_data_i,
  input  logic                imem_ready_i,
  output logic [`RV_XLEN-1:0] dmem_addr_o,
  output logic [`RV_XLEN-1:0] dmem_write_data_o,
  output logic                dmem_read_o,
  output logic                dmem_write_o,
  input  logic [`RV_XLEN-1:0] dmem_read_data_i,
  input  logic                dmem_ready_i,
  output logic [`RV_XLEN-1:0] debug_pc_o
);

  // Step strobes and completions
  logic fetch_start, exec_en, mem_start, wb_en;
  logic fetch_done, mem_done;

  logic [`RV_XLEN-1:0]       pc, inst, imm;
  logic [`RV_REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
  alu_op_e                   alu_op;
  br_funct3_e                br_funct3;
  wb_src_e                   wb_src;
  logic                      alu_src_imm, reg_write;
  logic                      is_load, is_store, is_branch, is_jal;
  logic [`RV_XLEN-1:0]       rs1_data, rs2_data;
  logic [`RV_XLEN-1:0]       alu_result, store_data, next_pc;
  logic                      rd_we;
  logic [`RV_XLEN-1:0]       rd_data;

  rv_core_fsm u_fsm (
    .clk(clk), .rst_n(rst_n),
    .fetch_done_i(fetch_done), .mem_done_i(mem_done),
    .is_load_i(is_load), .is_store_i(is_store),
    .fetch_start_o(fetch_start),
    // Decode is combinational from the instruction register
    .decode_en_o(),
    .exec_en_o(exec_en), .mem_start_o(mem_start), .wb_en_o(wb_en)
  );

  rv_fetch u_fetch (
    .clk(clk), .rst_n(rst_n),
    .fetch_start_i(fetch_start), .wb_en_i(wb_en), .next_pc_i(next_pc),
    .imem_addr_o(imem_addr_o), .imem_read_o(imem_read_o),
    .imem_read_data_i(imem_read_data_i), .imem_ready_i(imem_ready_i),
    .pc_o(pc), .inst_o(inst), .fetch_done_o(fetch_done)
  );

  rv_decode u_decode (
    .inst_i(inst),
    .rs1_o(rs1_addr), .rs2_o(rs2_addr), .rd_o(rd_addr), .imm_o(imm),
    .alu_op_o(alu_op), .alu_src_imm_o(alu_src_imm), .reg_write_o(reg_write),
    .is_load_o(is_load), .is_store_o(is_store),
    .is_branch_o(is_branch), .is_jal_o(is_jal),
    .br_funct3_o(br_funct3), .wb_src_o(wb_src)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst_n(rst_n),
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(rd_we), .rd_addr_i(rd_addr), .rd_data_i(rd_data)
  );

  rv_execute u_execute (
    .clk(clk), .rst_n(rst_n), .exec_en_i(exec_en), .pc_i(pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm),
    .alu_op_i(alu_op), .alu_src_imm_i(alu_src_imm),
    .is_branch_i(is_branch), .is_jal_i(is_jal), .br_funct3_i(br_funct3),
    .alu_result_o(alu_result), .store_data_o(store_data), .next_pc_o(next_pc)
  );

  // Load/store address is the ALU sum rs1 + imm
  rv_mem_access u_mem_access (
    .clk(clk), .rst_n(rst_n), .mem_start_i(mem_start), .wb_en_i(wb_en),
    .is_load_i(is_load), .is_store_i(is_store),
    .addr_i(alu_result), .store_data_i(store_data),
    .alu_result_i(alu_result), .pc_i(pc),
    .wb_src_i(wb_src), .reg_write_i(reg_write),
    .dmem_addr_o(dmem_addr_o), .dmem_write_data_o(dmem_write_data_o),
    .dmem_read_o(dmem_read_o), .dmem_write_o(dmem_write_o),
    .dmem_read_data_i(dmem_read_data_i), .dmem_ready_i(dmem_ready_i),
    .mem_done_o(mem_done), .rd_we_o(rd_we), .rd_data_o(rd_data)
  );

  assign debug_pc_o = pc;

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

  localparam int          IMEM_WORDS     = 64;
  localparam int          DMEM_WORDS     = 16;
  localparam int          MAX_STEPS      = 100;
  localparam int          TIMEOUT_CYCLES = 5000;
  localparam logic [31:0] LFSR_SEED      = 32'h056bc34e;
  // JAL x0, 0
  localparam logic [31:0] SELF_JUMP      = 32'h0000_006f;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic        imem_read;
  logic [31:0] imem_rdata;
  logic        imem_ready;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_read;
  logic        dmem_write;
  logic [31:0] dmem_rdata;
  logic        dmem_ready;
  logic [31:0] debug_pc;

  logic [31:0] imem_mem [IMEM_WORDS];
  logic [31:0] dmem_mem [DMEM_WORDS];
  logic [31:0] dmem_model [DMEM_WORDS];
  logic [31:0] exp_pc_q [$];
  logic [31:0] exp_st_addr_q [$];
  logic [31:0] exp_st_data_q [$];

  logic [31:0] lfsr_q;
  int          imem_wait;
  int          dmem_wait;
  int          errors;
  int          fetch_cnt;
  int          store_cnt;

  // Request state seen at the previous edge
  logic        prev_ireq;
  logic        prev_irdy;
  logic [31:0] prev_iaddr;
  logic        prev_dreq;
  logic        prev_drdy;
  logic        prev_dread;
  logic        prev_dwrite;
  logic [31:0] prev_daddr;

  rv_core_top u_dut (
    .clk(clk), .rst_n(rst_n),
    .imem_addr_o(imem_addr), .imem_read_o(imem_read),
    .imem_read_data_i(imem_rdata), .imem_ready_i(imem_ready),
    .dmem_addr_o(dmem_addr), .dmem_write_data_o(dmem_wdata),
    .dmem_read_o(dmem_read), .dmem_write_o(dmem_write),
    .dmem_read_data_i(dmem_rdata), .dmem_ready_i(dmem_ready),
    .debug_pc_o(debug_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==================================================
  // Random numbers and reference helpers
  // ==================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'hda7a_0000 + idx * 32'h0001_0203;
  endfunction

  // RV32I integer ALU by funct3 with alt picking SUB or SRA
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else     r = a >> b[4:0];
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // ==================================================
  // Program generator and instruction-set model
  // ==================================================
  task automatic gen_program();
    logic [31:0] ins;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    int          tgt;
    for (int i = 0; i < IMEM_WORDS - 1; i++) begin
      // Small register set so results feed later instructions
      rd  = 5'(rand_bits(3));
      rs1 = 5'(rand_bits(3));
      rs2 = 5'(rand_bits(3));
      f3  = 3'(rand_bits(3));
      tgt = i + 1 + int'(rand_bits(2));
      if (tgt > IMEM_WORDS - 1) tgt = IMEM_WORDS - 1;
      case (rand_bits(4))
        0, 1, 2: begin
          imm[11:5] = ((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1)) ? 7'b0100000 : 7'b0;
          ins = {imm[11:5], rs2, rs1, f3, rd, 7'b0110011};
        end
        3, 4, 5: begin
          imm = 12'(rand_bits(12));
          if (f3 == 3'b001) imm[11:5] = 7'b0;
          if (f3 == 3'b101) imm[11:5] = rand_bits(1) ? 7'b0100000 : 7'b0;
          ins = {imm, rs1, f3, rd, 7'b0010011};
        end
        6: ins = {20'(rand_bits(20)), rd, 7'b0110111};
        7, 15: ins = {6'd0, 4'(rand_bits(4)), 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
        8, 9, 10: begin
          imm = {6'd0, 4'(rand_bits(4)), 2'b00};
          ins = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
        end
        11, 12: begin
          boff = 13'((tgt - i) * 4);
          ins = {boff[12], boff[10:5], rs2, rs1, 2'b00, f3[0], boff[4:1], boff[11],
                 7'b1100011};
        end
        13: begin
          joff = 21'((tgt - i) * 4);
          ins = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
        end
        // Custom-0 opcode that retires as a no-op
        default: ins = {25'(rand_bits(25)), 7'b0001011};
      endcase
      imem_mem[i] = ins;
    end
    imem_mem[IMEM_WORDS - 1] = SELF_JUMP;
  endtask

  task automatic model_run();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [2:0]  f3;
    logic        wr;
    logic        done;
    int          steps;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < MAX_STEPS) begin
      exp_pc_q.push_back(pc);
      ins     = imem_mem[pc[7:2]];
      f3      = ins[14:12];
      a       = regs[ins[19:15]];
      b       = regs[ins[24:20]];
      next_pc = pc + 32'd4;
      wr      = 1'b0;
      res     = '0;
      case (ins[6:0])
        7'b0110011: begin
          res = alu_ref(f3, ins[30], a, b);
          wr  = 1'b1;
        end
        7'b0010011: begin
          res = alu_ref(f3, (f3 == 3'b101) && ins[30], a, {{20{ins[31]}}, ins[31:20]});
          wr  = 1'b1;
        end
        7'b0110111: begin
          res = {ins[31:12], 12'h000};
          wr  = 1'b1;
        end
        7'b0000011: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          res  = dmem_model[addr[5:2]];
          wr   = 1'b1;
        end
        7'b0100011: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          dmem_model[addr[5:2]] = b;
          exp_st_addr_q.push_back(addr);
          exp_st_data_q.push_back(b);
        end
        7'b1100011: begin
          if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
            next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        7'b1101111: begin
          res     = pc + 32'd4;
          wr      = 1'b1;
          next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: ;
      endcase
      if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
      // The final jump to itself is fetched once more
      if (next_pc == pc) begin
        exp_pc_q.push_back(pc);
        done = 1'b1;
      end
      pc = next_pc;
      steps++;
    end
  endtask

  // ==================================================
  // Memory models with random ready delay
  // ==================================================
  always @(posedge clk) begin
    if (!rst_n) begin
      imem_ready <= 1'b0;
      dmem_ready <= 1'b0;
      imem_wait  <= 0;
      dmem_wait  <= 0;
    end else begin
      if (imem_ready) begin
        imem_ready <= 1'b0;
        imem_wait  <= int'(rand_bits(2));
      end else if (imem_read) begin
        if (imem_wait == 0) begin
          imem_ready <= 1'b1;
          imem_rdata <= imem_mem[imem_addr[7:2]];
        end else begin
          imem_wait <= imem_wait - 1;
        end
      end
      if (dmem_ready) begin
        dmem_ready <= 1'b0;
        dmem_wait  <= int'(rand_bits(2));
        if (dmem_write) dmem_mem[dmem_addr[5:2]] <= dmem_wdata;
      end else if (dmem_read || dmem_write) begin
        if (dmem_wait == 0) begin
          dmem_ready <= 1'b1;
          dmem_rdata <= dmem_mem[dmem_addr[5:2]];
        end else begin
          dmem_wait <= dmem_wait - 1;
        end
      end
    end
  end

  // Handshake monitor
  always @(posedge clk) begin
    if (rst_n) begin
      if (prev_ireq && !prev_irdy) begin
        check_value("imem_read_o", 32'd1, {31'd0, imem_read});
        check_value("imem_addr_o", prev_iaddr, imem_addr);
      end
      if (prev_dreq && !prev_drdy) begin
        check_value("dmem_read_o", {31'd0, prev_dread}, {31'd0, dmem_read});
        check_value("dmem_write_o", {31'd0, prev_dwrite}, {31'd0, dmem_write});
        check_value("dmem_addr_o", prev_daddr, dmem_addr);
      end
      if (dmem_read && dmem_write) begin
        $display("Error at %0t: data read and write requested in the same cycle", $time);
        errors++;
      end
      if (imem_read && imem_ready) begin
        if (fetch_cnt < exp_pc_q.size()) begin
          check_value("imem_addr_o", exp_pc_q[fetch_cnt], imem_addr);
          check_value("debug_pc_o", exp_pc_q[fetch_cnt], debug_pc);
        end
        fetch_cnt++;
      end
      if (dmem_write && dmem_ready) begin
        if (store_cnt < exp_st_addr_q.size()) begin
          check_value("dmem_addr_o", exp_st_addr_q[store_cnt], dmem_addr);
          check_value("dmem_write_data_o", exp_st_data_q[store_cnt], dmem_wdata);
        end else begin
          $display("Error at %0t: the core stored more words than the program holds", $time);
          errors++;
        end
        store_cnt++;
      end
    end
    prev_ireq   = imem_read;
    prev_irdy   = imem_ready;
    prev_iaddr  = imem_addr;
    prev_dreq   = dmem_read || dmem_write;
    prev_drdy   = dmem_ready;
    prev_dread  = dmem_read;
    prev_dwrite = dmem_write;
    prev_daddr  = dmem_addr;
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int cycles;
    rst_n       = 1'b0;
    imem_ready  = 1'b0;
    imem_rdata  = '0;
    dmem_ready  = 1'b0;
    dmem_rdata  = '0;
    imem_wait   = 0;
    dmem_wait   = 0;
    errors      = 0;
    fetch_cnt   = 0;
    store_cnt   = 0;
    lfsr_q      = LFSR_SEED;
    prev_ireq   = 1'b0;
    prev_irdy   = 1'b0;
    prev_iaddr  = '0;
    prev_dreq   = 1'b0;
    prev_drdy   = 1'b0;
    prev_dread  = 1'b0;
    prev_dwrite = 1'b0;
    prev_daddr  = '0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem_mem[i]   = fill_word(i);
      dmem_model[i] = fill_word(i);
    end
    gen_program();
    model_run();

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("imem_read_o", 32'd0, {31'd0, imem_read});
    check_value("dmem_read_o", 32'd0, {31'd0, dmem_read});
    check_value("dmem_write_o", 32'd0, {31'd0, dmem_write});
    check_value("debug_pc_o", 32'd0, debug_pc);
    @(posedge clk);
    rst_n <= 1'b1;

    // Run until the final jump has been fetched twice
    cycles = 0;
    while (fetch_cnt < exp_pc_q.size() && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (fetch_cnt < exp_pc_q.size()) begin
      $display("Error: timed out after %0d cycles waiting for the final jump", cycles);
      errors++;
    end
    check_value("store count", exp_st_addr_q.size(), store_cnt);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      check_value($sformatf("dmem[%0d]", i), dmem_model[i], dmem_mem[i]);
    end

    $display("Errors: %0d, fetches: %0d, stores: %0d", errors, fetch_cnt, store_cnt);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_mem_access.sv
verilog/rv_core_fsm.sv
verilog/rv_core_top.sv
sim/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_ctrl_pkg.sv
      - verilog/rv_fetch.sv
      - verilog/rv_decode.sv
      - verilog/rv_regfile.sv
      - verilog/rv_execute.sv
      - verilog/rv_mem_access.sv
      - verilog/rv_core_fsm.sv
      - verilog/rv_core_top.sv
  - target: test
    files:
      - sim/tb_rv_core.sv
